/* hdl/sched_pkg.sv */
// Shared types for the integer ALU issue queue.
// Tags, ages and opcodes are plain vectors. The entry state machine
// uses the enum below. Ages wrap, so ordering goes through the
// wrap-aware comparison function at the end.

`default_nettype none

package sched_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int TAG_W = 6;  // 64 physical registers
  localparam int AGE_W = 6;  // Reorder buffer age that wraps
  localparam int OP_W  = 4;

  // ----------------------------------------------------------
  // Types
  // ----------------------------------------------------------
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [AGE_W-1:0] age_t;
  typedef logic [OP_W-1:0]  op_t;

  // Slot life cycle
  typedef enum logic [1:0] {
    ENTRY_IDLE   = 2'd0,
    ENTRY_WAIT   = 2'd1,
    ENTRY_ISSUED = 2'd2
  } entry_state_t;

  // ----------------------------------------------------------
  // Age comparison
  // ----------------------------------------------------------
  // True when a_age was allocated after b_age. Live ages never sit
  // more than 31 apart, so the sign of the 6-bit difference decides.
  // Equal ages are not younger.
  function automatic logic is_younger(age_t a_age, age_t b_age);
    age_t diff;
    diff = b_age - a_age;  // Negative when a is ahead of b
    return diff[AGE_W-1];
  endfunction

endpackage

`default_nettype wire

/* hdl/sched_bcast_if.sv */
// Broadcast bundle from the queue top to every scheduler slot.
// Carries the wakeup tag ports and the branch flush notice. All
// fields are single-cycle levels with no handshake.

`default_nettype none

interface sched_bcast_if #(
  parameter int NUM_WAKE = 3  // External write-back ports plus self-wake
);

  logic [NUM_WAKE-1:0] wake_valid;
  sched_pkg::tag_t     wake_tag [NUM_WAKE];
  logic                flush_valid;
  sched_pkg::age_t     flush_age;  // Entries younger than this die

  // Driven by the queue top
  modport source (
    output wake_valid, wake_tag, flush_valid, flush_age
  );

  // Read by each slot
  modport entry (
    input wake_valid, wake_tag, flush_valid, flush_age
  );

endinterface

`default_nettype wire

/* hdl/sched_issue_entry.sv */
// One slot of the ALU issue queue.
// Holds a dispatched instruction, tracks readiness of its two sources
// against the wakeup ports and drops out on a younger branch flush.
// Requests issue once both sources are ready; after the pick it spends
// one cycle in ISSUED and then frees itself.

`default_nettype none

module sched_issue_entry #(
  parameter int NUM_WB = 2
) (
  input  wire logic            i_clk,
  input  wire logic            i_reset_n,

  // Allocation
  input  wire logic            i_put,
  input  sched_pkg::op_t       i_put_op,
  input  sched_pkg::tag_t      i_put_dst,
  input  sched_pkg::tag_t      i_put_src0,
  input  sched_pkg::tag_t      i_put_src1,
  input  wire logic [1:0]      i_put_src_valid,
  input  wire logic [1:0]      i_put_src_ready,
  input  sched_pkg::age_t      i_put_age,

  input  wire logic            i_picked,  // Grant from the picker

  sched_bcast_if.entry         bcast,

  output logic                 o_valid,
  output logic                 o_request,
  output sched_pkg::age_t      o_age,
  output sched_pkg::op_t       o_op,
  output sched_pkg::tag_t      o_dst,
  output sched_pkg::tag_t      o_src0,
  output sched_pkg::tag_t      o_src1
);

  localparam int NUM_WAKE = NUM_WB + 1;

  sched_pkg::entry_state_t r_state;
  sched_pkg::entry_state_t w_state_next;

  sched_pkg::op_t  r_op;
  sched_pkg::tag_t r_dst;
  sched_pkg::tag_t r_src0;
  sched_pkg::tag_t r_src1;
  sched_pkg::age_t r_age;
  logic [1:0]      r_src_ready;

  sched_pkg::tag_t w_cmp_src0;
  sched_pkg::tag_t w_cmp_src1;
  logic [1:0]      w_wake_hit;
  logic            w_flush_kill;
  logic            w_put_kill;

  // ----------------------------------------------------------
  // Wakeup match
  // ----------------------------------------------------------
  // On a put the incoming tags are compared, so a write-back in the
  // dispatch cycle is not lost
  assign w_cmp_src0 = i_put ? i_put_src0 : r_src0;
  assign w_cmp_src1 = i_put ? i_put_src1 : r_src1;

  always_comb begin
    w_wake_hit = 2'b00;
    for (int p = 0; p < NUM_WAKE; p++) begin
      if (bcast.wake_valid[p] && (bcast.wake_tag[p] == w_cmp_src0)) begin
        w_wake_hit[0] = 1'b1;
      end
      if (bcast.wake_valid[p] && (bcast.wake_tag[p] == w_cmp_src1)) begin
        w_wake_hit[1] = 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // Flush
  // ----------------------------------------------------------
  assign w_flush_kill = bcast.flush_valid &&
                        sched_pkg::is_younger(r_age, bcast.flush_age);
  assign w_put_kill   = bcast.flush_valid &&
                        sched_pkg::is_younger(i_put_age, bcast.flush_age);

  // ----------------------------------------------------------
  // State machine
  // ----------------------------------------------------------
  always_comb begin
    w_state_next = r_state;
    case (r_state)
      sched_pkg::ENTRY_IDLE: begin
        if (i_put && !w_put_kill) begin
          w_state_next = sched_pkg::ENTRY_WAIT;
        end
      end
      sched_pkg::ENTRY_WAIT: begin
        if (w_flush_kill) begin
          w_state_next = sched_pkg::ENTRY_IDLE;
        end else if (i_picked) begin
          w_state_next = sched_pkg::ENTRY_ISSUED;
        end
      end
      sched_pkg::ENTRY_ISSUED: begin
        w_state_next = sched_pkg::ENTRY_IDLE;  // Slot free next cycle
      end
      default: begin
        w_state_next = sched_pkg::ENTRY_IDLE;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= sched_pkg::ENTRY_IDLE;
    end else begin
      r_state <= w_state_next;
    end
  end

  // Instruction fields and source ready bits
  always_ff @(posedge i_clk) begin
    if (i_put) begin
      r_op        <= i_put_op;
      r_dst       <= i_put_dst;
      r_src0      <= i_put_src0;
      r_src1      <= i_put_src1;
      r_age       <= i_put_age;
      // Unused source counts as ready
      r_src_ready <= ~i_put_src_valid | i_put_src_ready | w_wake_hit;
    end else begin
      r_src_ready <= r_src_ready | w_wake_hit;
    end
  end

  // ----------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------
  assign o_valid   = (r_state != sched_pkg::ENTRY_IDLE);
  // Built from registered ready bits only, which keeps the self-wake
  // path free of a combinational loop
  assign o_request = (r_state == sched_pkg::ENTRY_WAIT) && (&r_src_ready) &&
                     !w_flush_kill;
  assign o_age     = r_age;
  assign o_op      = r_op;
  assign o_dst     = r_dst;
  assign o_src0    = r_src0;
  assign o_src1    = r_src1;

endmodule

`default_nettype wire

/* hdl/sched_oldest_pick.sv */
// Oldest-first select for the ALU issue queue.
// Every requesting slot is compared against every other requester by
// wrapped age. The slot that no other requester beats gets the grant.
// Purely combinational; the grant is one-hot or all zero.

`default_nettype none

module sched_oldest_pick #(
  parameter int NUM_ENTRIES = 8
) (
  input  wire logic [NUM_ENTRIES-1:0] i_request,
  input  sched_pkg::age_t             i_age [NUM_ENTRIES],
  output logic [NUM_ENTRIES-1:0]      o_grant,
  output logic                        o_grant_valid
);

  logic [NUM_ENTRIES-1:0] w_beaten;  // Some other requester is older

  // ----------------------------------------------------------
  // Pairwise age matrix
  // ----------------------------------------------------------
  always_comb begin
    w_beaten = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      for (int j = 0; j < NUM_ENTRIES; j++) begin
        if (j != i && i_request[j]) begin
          // j is older than i
          if (sched_pkg::is_younger(i_age[i], i_age[j])) begin
            w_beaten[i] = 1'b1;
          end
          // Equal ages go to the lower index
          if ((i_age[i] == i_age[j]) && (j < i)) begin
            w_beaten[i] = 1'b1;
          end
        end
      end
    end
  end

  assign o_grant       = i_request & ~w_beaten;
  assign o_grant_valid = |o_grant;

endmodule

`default_nettype wire

/* hdl/sched_alu_queue.sv */
// Issue queue for an out-of-order integer ALU.
// Dispatch goes into the lowest free slot. Slots wake from the
// write-back tag ports and from this queue's own grant, so a dependent
// instruction can issue right behind its producer. Each cycle the
// oldest ready slot is picked and its fields are registered onto the
// issue port. A branch flush kills everything younger than its age.

`default_nettype none

module sched_alu_queue #(
  parameter int NUM_ENTRIES = 8,
  parameter int NUM_WB      = 2
) (
  input  wire logic              i_clk,
  input  wire logic              i_reset_n,

  // Dispatch
  input  wire logic              i_disp_valid,
  input  sched_pkg::op_t         i_disp_op,
  input  sched_pkg::tag_t        i_disp_dst,
  input  sched_pkg::tag_t        i_disp_src0,
  input  sched_pkg::tag_t        i_disp_src1,
  input  wire logic [1:0]        i_disp_src_valid,
  input  wire logic [1:0]        i_disp_src_ready,
  input  sched_pkg::age_t        i_disp_age,

  // Write-back tags and flush
  input  wire logic [NUM_WB-1:0] i_wb_valid,
  input  sched_pkg::tag_t        i_wb_tag [NUM_WB],
  input  wire logic              i_flush_valid,
  input  sched_pkg::age_t        i_flush_age,

  output logic                   o_full,

  // Issue port
  output logic                   o_issue_valid,
  output sched_pkg::op_t         o_issue_op,
  output sched_pkg::tag_t        o_issue_dst,
  output sched_pkg::tag_t        o_issue_src0,
  output sched_pkg::tag_t        o_issue_src1,
  output sched_pkg::age_t        o_issue_age
);

  logic [NUM_ENTRIES-1:0] w_entry_valid;
  logic [NUM_ENTRIES-1:0] w_entry_request;
  logic [NUM_ENTRIES-1:0] w_alloc;
  logic [NUM_ENTRIES-1:0] w_grant;
  logic                   w_grant_valid;
  sched_pkg::age_t        w_entry_age  [NUM_ENTRIES];
  sched_pkg::op_t         w_entry_op   [NUM_ENTRIES];
  sched_pkg::tag_t        w_entry_dst  [NUM_ENTRIES];
  sched_pkg::tag_t        w_entry_src0 [NUM_ENTRIES];
  sched_pkg::tag_t        w_entry_src1 [NUM_ENTRIES];

  sched_pkg::op_t         w_grant_op;
  sched_pkg::tag_t        w_grant_dst;
  sched_pkg::tag_t        w_grant_src0;
  sched_pkg::tag_t        w_grant_src1;
  sched_pkg::age_t        w_grant_age;

  sched_bcast_if #(.NUM_WAKE(NUM_WB + 1)) bcast ();

  // ----------------------------------------------------------
  // Allocation
  // ----------------------------------------------------------
  assign w_alloc = ~w_entry_valid & (w_entry_valid + 1'b1);  // Lowest idle slot
  assign o_full  = &w_entry_valid;

  // ----------------------------------------------------------
  // Broadcast
  // ----------------------------------------------------------
  assign bcast.wake_valid  = {w_grant_valid, i_wb_valid};
  assign bcast.flush_valid = i_flush_valid;
  assign bcast.flush_age   = i_flush_age;

  for (genvar w = 0; w < NUM_WB; w++) begin : g_wb_port
    assign bcast.wake_tag[w] = i_wb_tag[w];
  end
  assign bcast.wake_tag[NUM_WB] = w_grant_dst;  // Self-wake port for the one-cycle ALU

  // ----------------------------------------------------------
  // Slots and picker
  // ----------------------------------------------------------
  for (genvar e = 0; e < NUM_ENTRIES; e++) begin : g_entry
    sched_issue_entry #(
      .NUM_WB (NUM_WB)
    ) u_entry (
      .i_clk           (i_clk),
      .i_reset_n       (i_reset_n),
      .i_put           (i_disp_valid & w_alloc[e]),
      .i_put_op        (i_disp_op),
      .i_put_dst       (i_disp_dst),
      .i_put_src0      (i_disp_src0),
      .i_put_src1      (i_disp_src1),
      .i_put_src_valid (i_disp_src_valid),
      .i_put_src_ready (i_disp_src_ready),
      .i_put_age       (i_disp_age),
      .i_picked        (w_grant[e]),
      .bcast           (bcast),
      .o_valid         (w_entry_valid[e]),
      .o_request       (w_entry_request[e]),
      .o_age           (w_entry_age[e]),
      .o_op            (w_entry_op[e]),
      .o_dst           (w_entry_dst[e]),
      .o_src0          (w_entry_src0[e]),
      .o_src1          (w_entry_src1[e])
    );
  end

  sched_oldest_pick #(
    .NUM_ENTRIES (NUM_ENTRIES)
  ) u_pick (
    .i_request     (w_entry_request),
    .i_age         (w_entry_age),
    .o_grant       (w_grant),
    .o_grant_valid (w_grant_valid)
  );

  // One-hot select of the granted slot
  always_comb begin
    w_grant_op   = '0;
    w_grant_dst  = '0;
    w_grant_src0 = '0;
    w_grant_src1 = '0;
    w_grant_age  = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (w_grant[i]) begin
        w_grant_op   |= w_entry_op[i];
        w_grant_dst  |= w_entry_dst[i];
        w_grant_src0 |= w_entry_src0[i];
        w_grant_src1 |= w_entry_src1[i];
        w_grant_age  |= w_entry_age[i];
      end
    end
  end

  // ----------------------------------------------------------
  // Issue port
  // ----------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_issue_valid <= 1'b0;
    end else begin
      o_issue_valid <= w_grant_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_grant_valid) begin
      o_issue_op   <= w_grant_op;
      o_issue_dst  <= w_grant_dst;
      o_issue_src0 <= w_grant_src0;
      o_issue_src1 <= w_grant_src1;
      o_issue_age  <= w_grant_age;
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// Clock and reset source for the issue queue testbench.
// Free-running clock and an active-low reset that is held for a
// fixed number of cycles and released on a falling edge.

`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic o_clk,
  output logic o_reset_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial o_clk = 1'b0;
  always #(PERIOD_NS / 2) o_clk = ~o_clk;

  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;  // Released away from the active edge
  end

endmodule

`default_nettype wire

/* testbench/sched_alu_queue_assert.sv */
// Concurrent checks on the ALU issue queue, bound to its top level.
// Covers the dispatch rule, a known issue valid, single-cycle issue
// per slot and issue ordering against the previous cycle's flush.

`default_nettype none

module sched_alu_queue_assert #(
  parameter int NUM_ENTRIES = 8
) (
  input  wire logic                   i_clk,
  input  wire logic                   i_reset_n,
  input  wire logic                   i_disp_valid,
  input  wire logic                   i_full,
  input  wire logic                   i_issue_valid,
  input  sched_pkg::age_t             i_issue_age,
  input  wire logic                   i_flush_valid,
  input  sched_pkg::age_t             i_flush_age,
  input  wire logic [NUM_ENTRIES-1:0] i_grant
);
  timeunit 1ns;
  timeprecision 1ps;

  a_no_disp_full : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp_valid |-> !i_full)
    else $error("dispatch strobe raised while the queue is full");

  a_issue_known : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !$isunknown(i_issue_valid))
    else $error("issue valid is unknown");

  // A slot granted twice in a row would sit in ISSUED for two cycles
  a_issued_once : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_grant & $past(i_grant)) == '0)
    else $error("slot granted on two consecutive cycles");

  a_flush_order : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    ($past(i_flush_valid) && i_issue_valid) |->
      !sched_pkg::is_younger(i_issue_age, $past(i_flush_age)))
    else $error("issued an instruction younger than the last flush");

endmodule

bind sched_alu_queue sched_alu_queue_assert #(
  .NUM_ENTRIES (NUM_ENTRIES)
) u_assert (
  .i_clk         (i_clk),
  .i_reset_n     (i_reset_n),
  .i_disp_valid  (i_disp_valid),
  .i_full        (o_full),
  .i_issue_valid (o_issue_valid),
  .i_issue_age   (o_issue_age),
  .i_flush_valid (i_flush_valid),
  .i_flush_age   (i_flush_age),
  .i_grant       (w_grant)
);

`default_nettype wire

/* testbench/tb_sched_alu_queue.sv */
// Testbench for the ALU issue queue.
// Directed phases and a seeded random mix drive dispatch, write-back
// and flush on falling edges. A cycle model of the slots predicts the
// issue port and o_full, which are compared one falling edge later.

`default_nettype none

module tb_sched_alu_queue;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N             = 8;
  localparam int NWB           = 2;
  localparam int RANDOM_CYCLES = 400;
  localparam int DRAIN_MAX     = 60;
  localparam int TOTAL_CYCLES  = 10 + 5 * (20 + DRAIN_MAX) + RANDOM_CYCLES + DRAIN_MAX;

  logic clk;
  logic reset_n;
  logic disp_valid;
  sched_pkg::op_t  disp_op;
  sched_pkg::tag_t disp_dst;
  sched_pkg::tag_t disp_src0;
  sched_pkg::tag_t disp_src1;
  logic [1:0]      disp_sv;
  logic [1:0]      disp_sr;
  sched_pkg::age_t disp_age;
  logic [NWB-1:0]  wb_valid;
  sched_pkg::tag_t wb_tag [NWB];
  logic            flush_valid;
  sched_pkg::age_t flush_age;
  logic            full;
  logic            issue_valid;
  sched_pkg::op_t  issue_op;
  sched_pkg::tag_t issue_dst;
  sched_pkg::tag_t issue_src0;
  sched_pkg::tag_t issue_src1;
  sched_pkg::age_t issue_age;

  // Model slot state (0 idle, 1 waiting, 2 issued)
  int              m_state [N];
  sched_pkg::op_t  m_op    [N];
  sched_pkg::tag_t m_dst   [N];
  sched_pkg::tag_t m_src0  [N];
  sched_pkg::tag_t m_src1  [N];
  sched_pkg::age_t m_age   [N];
  logic [1:0]      m_rdy   [N];

  logic            exp_valid;
  logic            exp_full;
  sched_pkg::op_t  exp_op;
  sched_pkg::tag_t exp_dst;
  sched_pkg::tag_t exp_src0;
  sched_pkg::tag_t exp_src1;
  sched_pkg::age_t exp_age;

  logic            reg_ready [64];  // Register scoreboard
  sched_pkg::age_t next_age;
  logic [31:0]     rng;
  string           test_name;
  int              test_errors;
  int              total_errors;
  int              failed_tests;
  int              check_count;

  tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(8)) u_clk (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  sched_alu_queue #(.NUM_ENTRIES(N), .NUM_WB(NWB)) sched_alu_queue_i (
    .i_clk (clk), .i_reset_n (reset_n),
    .i_disp_valid (disp_valid), .i_disp_op (disp_op), .i_disp_dst (disp_dst),
    .i_disp_src0 (disp_src0), .i_disp_src1 (disp_src1),
    .i_disp_src_valid (disp_sv), .i_disp_src_ready (disp_sr), .i_disp_age (disp_age),
    .i_wb_valid (wb_valid), .i_wb_tag (wb_tag),
    .i_flush_valid (flush_valid), .i_flush_age (flush_age),
    .o_full (full), .o_issue_valid (issue_valid), .o_issue_op (issue_op),
    .o_issue_dst (issue_dst), .o_issue_src0 (issue_src0),
    .o_issue_src1 (issue_src1), .o_issue_age (issue_age)
  );

  function automatic logic [31:0] xorshift32();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  // True when a was allocated before b within half the 6-bit age ring
  function automatic logic older_than(sched_pkg::age_t a, sched_pkg::age_t b);
    sched_pkg::age_t d;
    d = b - a;
    return (d != 0) && (d < 32);
  endfunction

  function automatic logic model_busy();
    logic busy;
    busy = 1'b0;
    for (int i = 0; i < N; i++) busy |= (m_state[i] != 0);
    return busy;
  endfunction

  // Keeps live ages well inside the comparison window
  function automatic logic can_dispatch();
    int used;
    logic ok;
    sched_pkg::age_t d;
    used = 0;
    ok = 1'b1;
    for (int i = 0; i < N; i++) begin
      if (m_state[i] != 0) begin
        used++;
        d = next_age - m_age[i];
        if (d >= 24) ok = 1'b0;
      end
    end
    return ok && (used < N);
  endfunction

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic check_bit(string what, logic exp, logic act);
    check_count++;
    if (exp !== act) begin
      $display("FAIL %s %s expected %0b actual %0b", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_tag(string what, sched_pkg::tag_t exp, sched_pkg::tag_t act);
    check_count++;
    if (exp !== act) begin
      $display("FAIL %s %s expected %0d actual %0d", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_age(string what, sched_pkg::age_t exp, sched_pkg::age_t act);
    check_count++;
    if (exp !== act) begin
      $display("FAIL %s %s expected %0d actual %0d", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_op(string what, sched_pkg::op_t exp, sched_pkg::op_t act);
    check_count++;
    if (exp !== act) begin
      $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  // ------------------------------------------------------------
  // Cycle model
  // ------------------------------------------------------------
  task automatic model_update();
    int g;
    int alloc;
    int used;
    logic put;
    sched_pkg::tag_t self_tag;
    sched_pkg::tag_t c0;
    sched_pkg::tag_t c1;
    logic [1:0] hit;
    g = -1;
    alloc = -1;
    used = 0;
    self_tag = '0;
    for (int i = 0; i < N; i++) begin
      if (m_state[i] == 1 && (&m_rdy[i]) &&
          !(flush_valid && older_than(flush_age, m_age[i]))) begin
        if (g < 0 || older_than(m_age[i], m_age[g])) g = i;  // Ties keep lower index
      end
      if (alloc < 0 && m_state[i] == 0) alloc = i;
    end
    exp_valid = (g >= 0);
    if (g >= 0) begin
      exp_op   = m_op[g];
      exp_dst  = m_dst[g];
      exp_src0 = m_src0[g];
      exp_src1 = m_src1[g];
      exp_age  = m_age[g];
      self_tag = m_dst[g];
    end
    for (int i = 0; i < N; i++) begin
      put = disp_valid && (i == alloc);
      c0 = put ? disp_src0 : m_src0[i];
      c1 = put ? disp_src1 : m_src1[i];
      hit = 2'b00;
      for (int p = 0; p < NWB; p++) begin
        if (wb_valid[p] && wb_tag[p] == c0) hit[0] = 1'b1;
        if (wb_valid[p] && wb_tag[p] == c1) hit[1] = 1'b1;
      end
      if (g >= 0 && self_tag == c0) hit[0] = 1'b1;
      if (g >= 0 && self_tag == c1) hit[1] = 1'b1;
      case (m_state[i])
        0: if (put && !(flush_valid && older_than(flush_age, disp_age))) m_state[i] = 1;
        1: begin
          if (flush_valid && older_than(flush_age, m_age[i])) m_state[i] = 0;
          else if (i == g) m_state[i] = 2;
        end
        default: m_state[i] = 0;
      endcase
      if (put) begin
        m_op[i]   = disp_op;
        m_dst[i]  = disp_dst;
        m_src0[i] = disp_src0;
        m_src1[i] = disp_src1;
        m_age[i]  = disp_age;
        m_rdy[i]  = ~disp_sv | disp_sr | hit;
      end else begin
        m_rdy[i] = m_rdy[i] | hit;
      end
      if (m_state[i] != 0) used++;
    end
    exp_full = (used == N);
    if (disp_valid) reg_ready[disp_dst] = 1'b0;
    for (int p = 0; p < NWB; p++) if (wb_valid[p]) reg_ready[wb_tag[p]] = 1'b1;
    if (g >= 0) reg_ready[self_tag] = 1'b1;
    if (disp_valid) next_age++;
    if (flush_valid) next_age = flush_age + 1'b1;
  endtask

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------
  task automatic clear_inputs();
    disp_valid  = 1'b0;
    wb_valid    = '0;
    flush_valid = 1'b0;
  endtask

  task automatic put_instr(sched_pkg::tag_t dst, sched_pkg::tag_t s0,
                           sched_pkg::tag_t s1, logic [1:0] sv, logic [1:0] sr);
    if (can_dispatch()) begin
      disp_valid = 1'b1;
      disp_op    = sched_pkg::op_t'(xorshift32());
      disp_dst   = dst;
      disp_src0  = s0;
      disp_src1  = s1;
      disp_sv    = sv;
      disp_sr    = sr;
      disp_age   = next_age;
    end
  endtask

  // Inputs are already driven; advance one clock and compare
  task automatic run_cycle();
    model_update();
    @(negedge clk);
    check_bit("issue_valid", exp_valid, issue_valid);
    check_bit("full", exp_full, full);
    if (exp_valid && issue_valid) begin
      check_op("issue_op", exp_op, issue_op);
      check_tag("issue_dst", exp_dst, issue_dst);
      check_tag("issue_src0", exp_src0, issue_src0);
      check_tag("issue_src1", exp_src1, issue_src1);
      check_age("issue_age", exp_age, issue_age);
    end
    clear_inputs();
  endtask

  task automatic begin_test(string name);
    test_name   = name;
    test_errors = 0;
  endtask

  // Sweeps every tag on the write-back ports until the queue empties
  task automatic end_test();
    int n;
    n = 0;
    while (model_busy() && n < DRAIN_MAX) begin
      wb_valid  = '1;
      wb_tag[0] = sched_pkg::tag_t'(n);
      wb_tag[1] = sched_pkg::tag_t'(n + 32);
      run_cycle();
      n++;
    end
    run_cycle();
    run_cycle();
    if (model_busy()) begin
      $display("ERROR %s the queue did not drain", test_name);
      test_errors++;
    end
    $display("test %s done, mismatches %0d", test_name, test_errors);
    total_errors += test_errors;
    if (test_errors != 0) failed_tests++;
  endtask

  task automatic random_cycle();
    logic [31:0] r;
    sched_pkg::tag_t s0;
    sched_pkg::tag_t s1;
    r  = xorshift32();
    s0 = sched_pkg::tag_t'(r[15:12]);
    s1 = sched_pkg::tag_t'(r[19:16]);
    if (r[2:0] != 3'd0) begin
      put_instr(sched_pkg::tag_t'(r[11:8]), s0, s1, r[21:20], {reg_ready[s1], reg_ready[s0]});
    end
    for (int p = 0; p < NWB; p++) begin
      wb_valid[p] = r[22 + p];
      wb_tag[p]   = sched_pkg::tag_t'(xorshift32() % 16);
    end
    if (xorshift32() % 40 == 0) begin
      flush_valid = 1'b1;
      flush_age   = next_age - 1'b1 - sched_pkg::age_t'(r[31:30] % 3);
    end
    run_cycle();
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    rng = 32'd5102;
    clear_inputs();
    disp_op = '0;
    disp_dst = '0;
    disp_src0 = '0;
    disp_src1 = '0;
    disp_sv = '0;
    disp_sr = '0;
    disp_age = '0;
    wb_tag[0] = '0;
    wb_tag[1] = '0;
    flush_age = '0;
    for (int i = 0; i < N; i++) m_state[i] = 0;
    for (int t = 0; t < 64; t++) reg_ready[t] = 1'b1;
    next_age = '0;
    exp_valid = 1'b0;
    exp_full = 1'b0;
    total_errors = 0;
    failed_tests = 0;
    check_count = 0;
    @(posedge reset_n);
    @(negedge clk);

    begin_test("ready_issue");
    for (int k = 0; k < 10; k++) begin
      put_instr(sched_pkg::tag_t'(32 + k), sched_pkg::tag_t'(k), sched_pkg::tag_t'(k + 1),
                2'(xorshift32()), 2'b11);
      run_cycle();
    end
    end_test();

    begin_test("wb_wakeup");
    for (int k = 0; k < 4; k++) begin
      put_instr(sched_pkg::tag_t'(36 + k), sched_pkg::tag_t'(48 + k), 6'd5,
                k[0] ? 2'b11 : 2'b01, k[0] ? 2'b10 : 2'b00);
      run_cycle();
    end
    run_cycle();
    run_cycle();
    for (int k = 0; k < 4; k += 2) begin
      wb_valid  = 2'b11;
      wb_tag[0] = sched_pkg::tag_t'(48 + k);
      wb_tag[1] = sched_pkg::tag_t'(49 + k);
      run_cycle();
    end
    end_test();

    begin_test("self_chain");
    for (int k = 0; k < 6; k++) begin
      put_instr(sched_pkg::tag_t'(20 + k), (k == 0) ? 6'd1 : sched_pkg::tag_t'(19 + k),
                6'd2, 2'b01, (k == 0) ? 2'b01 : 2'b00);
      run_cycle();
    end
    end_test();

    begin_test("flush");
    for (int k = 0; k < 6; k++) begin
      put_instr(sched_pkg::tag_t'(40 + k), 6'd60, 6'd61, 2'b01, 2'b00);
      run_cycle();
    end
    flush_valid = 1'b1;
    flush_age   = next_age - 3'd4;  // Kills the three youngest
    put_instr(6'd50, 6'd1, 6'd2, 2'b00, 2'b00);
    run_cycle();
    wb_valid  = 2'b01;
    wb_tag[0] = 6'd60;
    run_cycle();
    end_test();

    begin_test("full");
    for (int k = 0; k < N + 2; k++) begin
      put_instr(sched_pkg::tag_t'(40 + k), 6'd62, 6'd0, 2'b01, 2'b00);
      run_cycle();
    end
    wb_valid  = 2'b01;
    wb_tag[0] = 6'd62;
    run_cycle();
    end_test();

    begin_test("random_mix");
    repeat (RANDOM_CYCLES) random_cycle();
    end_test();

    $display("tests 6, failed %0d, checks %0d, mismatches %0d",
             failed_tests, check_count, total_errors);
    if (failed_tests == 0 && total_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the cycle budget of all phases
  initial begin
    #(TOTAL_CYCLES * 20 + 1000);
    $display("ERROR watchdog expired before the tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
hdl/sched_pkg.sv
hdl/sched_bcast_if.sv
hdl/sched_issue_entry.sv
hdl/sched_oldest_pick.sv
hdl/sched_alu_queue.sv
testbench/tb_clock_gen.sv
testbench/sched_alu_queue_assert.sv
testbench/tb_sched_alu_queue.sv

/* Makefile */
# Verilator build and run for the ALU issue queue testbench

VERILATOR ?= verilator
TOP       ?= tb_sched_alu_queue
FILELIST  ?= sources.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= RESULT: FAIL
PASS_MSG  ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o sim

run: build
	./$(BUILD_DIR)/sim 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation incomplete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
